//--- rtl/sport_cfg.svh
`ifndef SPORT_CFG_SVH
`define SPORT_CFG_SVH

`default_nettype none

// --------------------
// Data path width
// --------------------
`define SPORT_DATA_W 16

// --------------------
// AC'97 presets
// --------------------
`define SPORT_AC97_FSDIV 16'h00FF

// ISCLK, ITFS and SLEN of 15
`define SPORT_AC97_SCTL 16'h420F

// Stored MWORD form, bits 10 to 8 map to MWORD 15 to 13 and bits 7 to 0 stay in place
`define SPORT_AC97_MWORD 12'h2FF

`default_nettype wire

`endif

//--- rtl/sportPkg.sv
`include "sport_cfg.svh"
`default_nettype none

package sportPkg;

  // --------------------
  // Register map
  // --------------------
  typedef enum logic [2:0]
  {
    REG_AUTO    = 3'd0,
    REG_FSDIV   = 3'd1,
    REG_SCLKDIV = 3'd2,
    REG_SCTL    = 3'd3,
    REG_MWORD   = 3'd4,
    REG_TXDATA  = 3'd5,
    REG_RXDATA  = 3'd6
  } regAddrT;

  // --------------------
  // Payload types
  // --------------------
  typedef logic [`SPORT_DATA_W-1:0] dataWordT;

  typedef logic [4:0] slenT;  // Word length minus one

endpackage

`default_nettype wire

//--- rtl/sportCtlRegs.sv
`include "sport_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module sportCtlRegs
(
  input  wire                          DSPCLK,
  input  wire                          RST,
  input  wire sportPkg::regAddrT       regAddr,
  input  wire                          regWe,
  input  wire sportPkg::dataWordT      dmdIn,
  output sportPkg::dataWordT           dmdOut,
  input  wire sportPkg::dataWordT      rxWord,
  input  wire [1:0]                    slot1Ext,
  input  wire [3:0]                    slotNum,
  output logic                         txLoad,
  output sportPkg::dataWordT           txWord,
  output sportPkg::dataWordT           fsDiv,
  output sportPkg::dataWordT           sclkDiv,
  output logic                         iSclk,
  output logic                         loopBack,
  output logic                         invTfs,
  output sportPkg::slenT               slen,
  output logic                         pdForce,
  output logic                         xtalDis
);

  import sportPkg::*;

  logic autoWe;
  logic fsDivWe;
  logic sclkDivWe;
  logic sctlWe;
  logic mwordWe;
  logic ac97Preset;
  logic ac97Mode;

  dataWordT autoReg;
  dataWordT sctlReg;
  dataWordT mwordRd;
  logic [10:0] mwStore;  // MWORD bits 15 to 13 and 7 to 0
  logic [10:0] mwNext;

  // --------------------
  // Address decode
  // --------------------
  assign autoWe    = regWe && (regAddr == REG_AUTO);
  assign fsDivWe   = regWe && (regAddr == REG_FSDIV);
  assign sclkDivWe = regWe && (regAddr == REG_SCLKDIV);
  assign sctlWe    = regWe && (regAddr == REG_SCTL);
  assign mwordWe   = regWe && (regAddr == REG_MWORD);
  assign txLoad    = regWe && (regAddr == REG_TXDATA);
  assign txWord    = dmdIn;

  assign ac97Preset = mwordWe && dmdIn[14];  // One MWORD write sets up the whole port

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      autoReg <= '0;
    else if (autoWe)
      autoReg <= dmdIn;
    else
      autoReg[13] <= 1'b0;  // Powerdown force lasts a single cycle
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      fsDiv <= '0;
    else if (ac97Preset)
      fsDiv <= `SPORT_AC97_FSDIV;
    else if (fsDivWe)
      fsDiv <= dmdIn;
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      sclkDiv <= '0;
    else if (sclkDivWe)
      sclkDiv <= dmdIn;
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      sctlReg <= '0;
    else if (ac97Preset)
      sctlReg <= `SPORT_AC97_SCTL;
    else if (sctlWe)
      sctlReg <= dmdIn;
  end

  // The preset keeps the written bit 13 on top of the fixed AC'97 word
  assign mwNext = ac97Preset ? (11'(`SPORT_AC97_MWORD) | {2'b00, dmdIn[13], 8'h00}) :
                               {dmdIn[15:13], dmdIn[7:0]};

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      mwStore <= '0;
    else if (mwordWe)
      mwStore <= mwNext;
  end

  // --------------------
  // Field outputs
  // --------------------
  assign loopBack = sctlReg[15];
  assign iSclk    = sctlReg[14];
  assign invTfs   = sctlReg[7];
  assign slen     = {mwStore[10], sctlReg[3:0]};  // MWORD bit 15 extends SLEN
  assign xtalDis  = autoReg[15];
  assign pdForce  = autoReg[13];

  // --------------------
  // Read-back
  // --------------------
  assign ac97Mode = mwStore[9];

  always_comb
  begin
    if (ac97Mode)
      mwordRd = {mwStore[10:9], slot1Ext, slotNum, mwStore[7:0]};  // Slot status replaces 13 to 8
    else
      mwordRd = {mwStore[10:8], 5'b00000, mwStore[7:0]};
  end

  always_comb
  begin
    case (regAddr)
      REG_AUTO:    dmdOut = autoReg;
      REG_FSDIV:   dmdOut = fsDiv;
      REG_SCLKDIV: dmdOut = sclkDiv;
      REG_SCTL:    dmdOut = sctlReg;
      REG_MWORD:   dmdOut = mwordRd;
      REG_RXDATA:  dmdOut = rxWord;
      default:     dmdOut = '0;  // TXDATA is write only
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/sportClkGen.sv
`timescale 1ns/1ns
`default_nettype none

module sportClkGen
(
  input  wire                     DSPCLK,
  input  wire                     RST,
  input  wire                     iSclk,
  input  wire sportPkg::dataWordT sclkDiv,
  input  wire sportPkg::dataWordT fsDiv,
  output logic                    sclkRise,
  output logic                    sclkFall,
  output logic                    tfsPulse
);

  import sportPkg::*;

  dataWordT divCnt;
  dataWordT fsCnt;
  logic sclkPhase;  // High between a rise and the following fall
  logic halfDone;

  // --------------------
  // Serial clock
  // --------------------
  assign halfDone = iSclk && (divCnt >= sclkDiv);
  assign sclkRise = halfDone && !sclkPhase;
  assign sclkFall = halfDone && sclkPhase;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      divCnt    <= '0;
      sclkPhase <= 1'b0;
    end
    else if (!iSclk)
    begin
      divCnt    <= '0;
      sclkPhase <= 1'b0;
    end
    else if (halfDone)
    begin
      divCnt    <= '0;
      sclkPhase <= !sclkPhase;
    end
    else
      divCnt <= divCnt + dataWordT'(1);
  end

  // --------------------
  // Frame sync
  // --------------------
  assign tfsPulse = sclkFall && (fsCnt == '0);  // First fall after enable starts a frame

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      fsCnt <= '0;
    else if (!iSclk)
      fsCnt <= '0;
    else if (sclkFall)
      fsCnt <= (fsCnt >= fsDiv) ? '0 : fsCnt + dataWordT'(1);
  end

endmodule

`default_nettype wire

//--- rtl/sportTx.sv
`timescale 1ns/1ns
`default_nettype none

module sportTx
(
  input  wire                     DSPCLK,
  input  wire                     RST,
  input  wire                     txLoad,
  input  wire sportPkg::dataWordT txWord,
  input  wire sportPkg::slenT     slen,
  input  wire                     invTfs,
  input  wire                     sclkFall,
  input  wire                     tfsPulse,
  output logic                    txSerial,
  output logic                    tfsOut,
  output logic                    txEmpty
);

  import sportPkg::*;

  localparam int DataW = $bits(dataWordT);

  dataWordT txBuf;
  dataWordT shiftReg;
  dataWordT alignedWord;
  slenT bitCnt;
  logic bufFull;
  logic shifting;
  logic tfsFlag;
  logic loadShift;

  assign loadShift = tfsPulse && bufFull;
  assign txEmpty   = loadShift;
  assign txSerial  = shiftReg[DataW-1];  // MSB first
  assign tfsOut    = tfsFlag ^ invTfs;

  // Put the top bit of the word at the MSB of the shifter
  always_comb
  begin
    if (slen >= slenT'(DataW - 1))
      alignedWord = txBuf;
    else
      alignedWord = txBuf << (slenT'(DataW - 1) - slen);
  end

  // --------------------
  // Transmit buffer
  // --------------------
  always_ff @(posedge DSPCLK)
  begin
    if (txLoad)
      txBuf <= txWord;
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
      bufFull <= 1'b0;
    else if (txLoad)
      bufFull <= 1'b1;  // A late write replaces the waiting word
    else if (loadShift)
      bufFull <= 1'b0;
  end

  // --------------------
  // Shifter
  // --------------------
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      shiftReg <= '0;
      bitCnt   <= '0;
      shifting <= 1'b0;
      tfsFlag  <= 1'b0;
    end
    else if (loadShift)
    begin
      shiftReg <= alignedWord;
      bitCnt   <= slen;
      shifting <= 1'b1;
      tfsFlag  <= 1'b1;
    end
    else if (sclkFall)
    begin
      tfsFlag <= 1'b0;  // Frame sync spans one serial clock period
      if (shifting)
      begin
        shiftReg <= shiftReg << 1;
        if (bitCnt == '0)
          shifting <= 1'b0;
        else
          bitCnt <= bitCnt - slenT'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/sportRx.sv
`timescale 1ns/1ns
`default_nettype none

module sportRx
(
  input  wire                 DSPCLK,
  input  wire                 RST,
  input  wire                 drSerial,
  input  wire                 frameStart,
  input  wire                 sclkRise,
  input  wire sportPkg::slenT slen,
  output sportPkg::dataWordT  rxWord,
  output logic                rxReady
);

  import sportPkg::*;

  localparam int DataW = $bits(dataWordT);

  dataWordT shiftReg;
  dataWordT shiftNext;
  slenT remaining;
  slenT remNext;
  logic active;
  logic sampleNow;
  logic wordDone;

  // --------------------
  // Sampling
  // --------------------
  assign sampleNow = sclkRise && (frameStart || active);

  // A frame sync restarts the word, with the first bit already on the line
  assign shiftNext = frameStart ? {{(DataW-1){1'b0}}, drSerial} :
                                  {shiftReg[DataW-2:0], drSerial};
  assign remNext   = frameStart ? slen : remaining - slenT'(1);
  assign wordDone  = sampleNow && (remNext == '0);

  always_ff @(posedge DSPCLK)
  begin
    if (sampleNow)
      shiftReg <= shiftNext;
  end

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      remaining <= '0;
      active    <= 1'b0;
    end
    else if (sampleNow)
    begin
      remaining <= remNext;
      active    <= !wordDone;
    end
  end

  // --------------------
  // Receive buffer
  // --------------------
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      rxWord  <= '0;
      rxReady <= 1'b0;
    end
    else
    begin
      rxReady <= wordDone;
      if (wordDone)
        rxWord <= shiftNext;  // Right aligned, upper bits zero
    end
  end

endmodule

`default_nettype wire

//--- rtl/sportTop.sv
`timescale 1ns/1ns
`default_nettype none

module sportTop
(
  input  wire                     DSPCLK,
  input  wire                     RST,
  input  wire sportPkg::regAddrT  regAddr,
  input  wire                     regWe,
  input  wire sportPkg::dataWordT dmdIn,
  output sportPkg::dataWordT      dmdOut,
  input  wire [1:0]               slot1Ext,
  input  wire [3:0]               slotNum,
  input  wire                     drIn,
  output logic                    dtOut,
  output logic                    tfsOut,
  output logic                    rxReady,
  output logic                    txEmpty,
  output logic                    pdForce,
  output logic                    xtalDis
);

  import sportPkg::*;

  dataWordT txWord;
  dataWordT fsDiv;
  dataWordT sclkDiv;
  dataWordT rxWord;
  slenT slen;
  logic txLoad;
  logic iSclk;
  logic loopBack;
  logic invTfs;
  logic sclkRise;
  logic sclkFall;
  logic tfsPulse;
  logic txSerial;
  logic drSerial;
  logic frameStart;

  // --------------------
  // Serial paths
  // --------------------
  assign dtOut      = txSerial;
  assign drSerial   = loopBack ? txSerial : drIn;  // Internal loopback
  assign frameStart = tfsOut ^ invTfs;  // Receive frame follows transmit frame

  sportCtlRegs ctlRegs_i
  (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .regAddr  (regAddr),
    .regWe    (regWe),
    .dmdIn    (dmdIn),
    .dmdOut   (dmdOut),
    .rxWord   (rxWord),
    .slot1Ext (slot1Ext),
    .slotNum  (slotNum),
    .txLoad   (txLoad),
    .txWord   (txWord),
    .fsDiv    (fsDiv),
    .sclkDiv  (sclkDiv),
    .iSclk    (iSclk),
    .loopBack (loopBack),
    .invTfs   (invTfs),
    .slen     (slen),
    .pdForce  (pdForce),
    .xtalDis  (xtalDis)
  );

  sportClkGen clkGen_i
  (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .iSclk    (iSclk),
    .sclkDiv  (sclkDiv),
    .fsDiv    (fsDiv),
    .sclkRise (sclkRise),
    .sclkFall (sclkFall),
    .tfsPulse (tfsPulse)
  );

  sportTx tx_i
  (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .txLoad   (txLoad),
    .txWord   (txWord),
    .slen     (slen),
    .invTfs   (invTfs),
    .sclkFall (sclkFall),
    .tfsPulse (tfsPulse),
    .txSerial (txSerial),
    .tfsOut   (tfsOut),
    .txEmpty  (txEmpty)
  );

  sportRx rx_i
  (
    .DSPCLK     (DSPCLK),
    .RST        (RST),
    .drSerial   (drSerial),
    .frameStart (frameStart),
    .sclkRise   (sclkRise),
    .slen       (slen),
    .rxWord     (rxWord),
    .rxReady    (rxReady)
  );

endmodule

`default_nettype wire

//--- tests/sportChk.sv
`timescale 1ns/1ns
`default_nettype none

module sportChk
(
  input wire DSPCLK,
  input wire RST,
  input wire rxReady,
  input wire pdForce,
  input wire tfsOut,
  input wire invTfs
);

  int rxFails = 0;
  int pdFails = 0;
  int tfsFails = 0;

  // --------------------
  // Pulse widths
  // --------------------
  rxReadyPulse: assert property (@(posedge DSPCLK) disable iff (RST) rxReady |=> !rxReady)
  else
  begin
    rxFails = rxFails + 1;
    $error("rxReady stayed high for two cycles");
  end

  pdForcePulse: assert property (@(posedge DSPCLK) disable iff (RST) $rose(pdForce) |=> !pdForce)
  else
  begin
    pdFails = pdFails + 1;
    $error("pdForce stayed high after its first cycle");
  end

  // --------------------
  // Reset state
  // --------------------
  tfsInReset: assert property (@(posedge DSPCLK) RST |-> (tfsOut == invTfs))
  else
  begin
    tfsFails = tfsFails + 1;
    $error("tfsOut active during reset");
  end

endmodule

`default_nettype wire

//--- tests/sportTb.sv
`include "sport_cfg.svh"
`timescale 1ns/1ns
`default_nettype none

module sportTb;

  import sportPkg::*;

  localparam int WaitLimit = 2000;
  localparam int NumWords = 12;
  localparam dataWordT CtlLoop = 16'hC000;  // LOOP and ISCLK
  localparam dataWordT CtlSclk = 16'h4000;  // ISCLK only
  localparam dataWordT CtlInvTfs = 16'h0080;

  logic DSPCLK = 1'b0;
  logic RST;
  regAddrT regAddr;
  logic regWe;
  dataWordT dmdIn;
  dataWordT dmdOut;
  logic [1:0] slot1Ext;
  logic [3:0] slotNum;
  logic drIn;
  logic dtOut;
  logic tfsOut;
  logic rxReady;
  logic txEmpty;
  logic pdForce;
  logic xtalDis;

  logic [15:0] lfsr;
  logic extLoop;
  logic timedOut;
  dataWordT expWord;
  int sentCount;
  int mainErrors;
  int rxCount = 0;
  int rxErrors = 0;
  int pdCount = 0;
  int emptyCount = 0;

  sportTop dut_i
  (
    .DSPCLK   (DSPCLK),
    .RST      (RST),
    .regAddr  (regAddr),
    .regWe    (regWe),
    .dmdIn    (dmdIn),
    .dmdOut   (dmdOut),
    .slot1Ext (slot1Ext),
    .slotNum  (slotNum),
    .drIn     (drIn),
    .dtOut    (dtOut),
    .tfsOut   (tfsOut),
    .rxReady  (rxReady),
    .txEmpty  (txEmpty),
    .pdForce  (pdForce),
    .xtalDis  (xtalDis)
  );

  bind sportTop sportChk chk_i
  (
    .DSPCLK  (DSPCLK),
    .RST     (RST),
    .rxReady (rxReady),
    .pdForce (pdForce),
    .tfsOut  (tfsOut),
    .invTfs  (invTfs)
  );

  always #10 DSPCLK = ~DSPCLK;

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [15:0] lfsrStep(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];  // x^16 + x^14 + x^13 + x^11 + 1
    return {state[14:0], fb};
  endfunction

  function automatic dataWordT randomBits(input int count);
    dataWordT val;
    int i;
    val = '0;
    for (i = 0; i < count; i++)
    begin
      lfsr = lfsrStep(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
    return val;
  endfunction

  // Only the low slen+1 bits travel over the line
  function automatic dataWordT expectRx(input dataWordT word, input slenT len);
    logic [31:0] mask;
    mask = (32'd1 << (32'(len) + 32'd1)) - 32'd1;
    return word & mask[15:0];
  endfunction

  // --------------------
  // Checks and waits
  // --------------------
  task automatic checkValue(input string name, input dataWordT actual, input dataWordT expected,
                            inout int errCount);
    if (actual !== expected)
    begin
      errCount++;
      $display("ERROR %0t ns %s: got %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic noteTimeout(input string what);
    $display("Timed out at %0t ns waiting for %s", $time, what);
    timedOut = 1'b1;
  endtask

  task automatic waitWords();
    int cycles;
    cycles = 0;
    while (!timedOut && (rxCount < sentCount) && (cycles < WaitLimit))
    begin
      @(posedge DSPCLK);
      cycles++;
    end
    if (!timedOut && (rxCount < sentCount))
      noteTimeout("a looped back word");
  endtask

  task automatic waitTfs(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (!timedOut && (tfsOut !== level) && (cycles < WaitLimit))
    begin
      @(negedge DSPCLK);
      cycles++;
    end
    if (!timedOut && (tfsOut !== level))
      noteTimeout(what);
  endtask

  // --------------------
  // Register bus
  // --------------------
  task automatic writeReg(input regAddrT addr, input dataWordT data);
    @(posedge DSPCLK);
    #2;
    regAddr = addr;
    dmdIn   = data;
    regWe   = 1'b1;
    @(posedge DSPCLK);
    #2;
    regWe = 1'b0;
  endtask

  task automatic readReg(input regAddrT addr, input dataWordT expected, input string name);
    @(posedge DSPCLK);
    #2;
    regAddr = addr;
    @(negedge DSPCLK);
    checkValue(name, dmdOut, expected, mainErrors);
  endtask

  task automatic sendWord(input dataWordT ctl, input dataWordT word, input slenT len);
    writeReg(REG_SCTL, ctl | dataWordT'(len[3:0]));
    expWord = expectRx(word, len);
    sentCount++;
    writeReg(REG_TXDATA, word);
    regAddr = REG_RXDATA;  // Comparison process reads the word back here
  endtask

  always @(posedge DSPCLK)
  begin
    #2;
    drIn = extLoop & dtOut;  // Pin loop from dtOut back to drIn while LOOP is off
  end

  always @(negedge DSPCLK)
  begin
    if (pdForce)
      pdCount <= pdCount + 1;
    if (txEmpty)
      emptyCount <= emptyCount + 1;
  end

  always @(negedge DSPCLK)
  begin
    if (rxReady)
    begin
      if (rxCount >= sentCount)
      begin
        rxErrors++;
        $display("A word was received at %0t ns while none was written", $time);
      end
      else
      begin
        checkValue("dmdOut(RXDATA)", dmdOut, expWord, rxErrors);
        rxCount++;
      end
    end
  end

  initial
  begin
    dataWordT word;
    dataWordT value;
    logic [11:0] presetMw;
    slenT len;
    int pdStart;
    int assertFails;
    int i;
    RST        = 1'b1;
    regAddr    = REG_AUTO;
    regWe      = 1'b0;
    dmdIn      = '0;
    slot1Ext   = 2'b10;
    slotNum    = 4'h5;
    drIn       = 1'b0;
    extLoop    = 1'b0;
    timedOut   = 1'b0;
    lfsr       = 16'd83;
    expWord    = '0;
    sentCount  = 0;
    mainErrors = 0;
    repeat (8) @(posedge DSPCLK);
    #2;
    RST = 1'b0;

    readReg(REG_AUTO, 16'h0000, "AUTO");
    readReg(REG_SCTL, 16'h0000, "SCTL");
    readReg(REG_MWORD, 16'h0000, "MWORD");

    writeReg(REG_FSDIV, 16'h1234);
    readReg(REG_FSDIV, 16'h1234, "FSDIV");
    writeReg(REG_SCLKDIV, 16'h00A7);
    readReg(REG_SCLKDIV, 16'h00A7, "SCLKDIV");
    writeReg(REG_SCTL, 16'h3C5A);
    readReg(REG_SCTL, 16'h3C5A, "SCTL");
    value = 16'hA5C3;
    writeReg(REG_MWORD, value);
    readReg(REG_MWORD, value & 16'hE0FF, "MWORD");  // Bits 12 to 8 read as zero

    // AC'97 preset from a single MWORD write
    writeReg(REG_MWORD, 16'h4000);
    readReg(REG_FSDIV, `SPORT_AC97_FSDIV, "FSDIV");
    readReg(REG_SCTL, `SPORT_AC97_SCTL, "SCTL");
    presetMw = `SPORT_AC97_MWORD;
    readReg(REG_MWORD, {presetMw[10:9], slot1Ext, slotNum, presetMw[7:0]}, "MWORD");
    slotNum = 4'hA;
    readReg(REG_MWORD, {presetMw[10:9], slot1Ext, slotNum, presetMw[7:0]}, "MWORD");
    writeReg(REG_MWORD, 16'h0000);

    pdStart = pdCount;
    value = 16'hA0C4;
    writeReg(REG_AUTO, value);
    readReg(REG_AUTO, value & ~16'h2000, "AUTO");  // Powerdown force clears itself
    checkValue("pdForce pulses", dataWordT'(pdCount - pdStart), 16'h0001, mainErrors);
    checkValue("xtalDis", dataWordT'(xtalDis), 16'h0001, mainErrors);
    writeReg(REG_AUTO, 16'h0000);
    readReg(REG_AUTO, 16'h0000, "AUTO");
    checkValue("xtalDis", dataWordT'(xtalDis), 16'h0000, mainErrors);
    checkValue("pdForce pulses", dataWordT'(pdCount - pdStart), 16'h0001, mainErrors);

    // --------------------
    // Loopback words
    // --------------------
    writeReg(REG_SCLKDIV, 16'd1);
    writeReg(REG_FSDIV, 16'd19);  // Frame longer than the longest word
    for (i = 0; (i < NumWords) && !timedOut; i++)
    begin
      len  = slenT'(3 + (randomBits(4) % 13));
      word = randomBits(16);
      sendWord(CtlLoop, word, len);
      waitWords();
    end

    if (!timedOut)
    begin
      extLoop = 1'b1;
      writeReg(REG_SCTL, CtlSclk | CtlInvTfs | 16'h0007);
      @(negedge DSPCLK);
      checkValue("tfsOut", dataWordT'(tfsOut), 16'h0001, mainErrors);  // Inverted sync idles high
      sendWord(CtlSclk | CtlInvTfs, randomBits(16), slenT'(7));
      waitTfs(1'b0, "tfsOut to go low");
      waitTfs(1'b1, "tfsOut to return high");
      waitWords();
      checkValue("txEmpty pulses", dataWordT'(emptyCount), dataWordT'(sentCount), mainErrors);
    end

    assertFails = dut_i.chk_i.rxFails + dut_i.chk_i.pdFails + dut_i.chk_i.tfsFails;
    $display("Errors: %0d register, %0d receive, %0d assertion; words received: %0d",
             mainErrors, rxErrors, assertFails, rxCount);
    if (!timedOut && ((mainErrors + rxErrors + assertFails) == 0))
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/sportPkg.sv
rtl/sportCtlRegs.sv
rtl/sportClkGen.sv
rtl/sportTx.sv
rtl/sportRx.sv
rtl/sportTop.sv
tests/sportChk.sv
tests/sportTb.sv

//--- Makefile
TOP = sportTb

.PHONY: all lint clean

# Build, run, then decide pass or fail from the log
all:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o Vsim
	./obj_dir/Vsim +verilator+error+limit+100 | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module sportTop

clean:
	rm -rf obj_dir sim.log
